/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_sdram_cache
FILELIST  ?= sdram_cache.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@output="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* design/sdram_cache_bram.sv */
// single-port synchronous RAM with per-byte write enables and a registered read
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_bram #(
  parameter int address_bits = 4
) (
  input  wire                              clk,
  input  wire sdram_cache_pkg::byte_en_t   write_enable,
  input  wire [address_bits-1:0]           address,
  input  wire sdram_cache_pkg::word_t      data_in,
  output sdram_cache_pkg::word_t           data_out
);

  localparam int bytes = $bits(sdram_cache_pkg::byte_en_t);
  localparam int depth = 2 ** address_bits;

  sdram_cache_pkg::word_t mem [depth];

  // read returns the word as it was before a write in the same cycle
  always_ff @(posedge clk) begin
    for (int b = 0; b < bytes; b++) begin
      if (write_enable[b]) begin
        mem[address][8*b +: 8] <= data_in[8*b +: 8];
      end
    end
    data_out <= mem[address];
  end

endmodule

`default_nettype wire

/* design/sdram_cache_ctrl.sv */
// cache control FSM: init refresh, hit service, write-back and line fill bursts
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_ctrl #(
  parameter int column_bits = 3,
  parameter int line_bits = 4,
  parameter int ram_addr_bits = 21,
  parameter int read_latency = 4,
  parameter int write_recovery = 4,
  localparam int tag_bits = ram_addr_bits - line_bits - column_bits
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               enable,
  input  wire sdram_cache_pkg::byte_en_t    write_enable,
  input  wire [tag_bits-1:0]                address_tag,
  input  wire [line_bits-1:0]               line_index,
  input  wire                               hit,
  input  wire                               line_dirty,
  input  wire [tag_bits-1:0]                cached_tag,
  input  wire sdram_cache_pkg::word_t       line_word,
  output logic                              busy,
  output logic                              data_out_ready,
  output logic                              store_write,
  output logic                              fill_active,
  output logic                              fill_we,
  output logic [column_bits-1:0]            fill_column,
  output sdram_cache_pkg::word_t            fill_data,
  output logic                              tag_fill_we,
  output logic                              sdrc_cmd_en,
  output sdram_cache_pkg::sdrc_cmd_t        sdrc_cmd,
  output sdram_cache_pkg::sdrc_addr_t       sdrc_addr,
  output sdram_cache_pkg::word_t            sdrc_data,
  output sdram_cache_pkg::data_len_t        sdrc_data_len,
  input  wire sdram_cache_pkg::word_t       sdrc_data_in,
  input  wire                               sdrc_init_done,
  input  wire                               sdrc_cmd_ack
);

  localparam int columns = 2 ** column_bits;

  typedef enum logic [3:0] {
    st_init_refresh,
    st_init_wait,
    st_idle,
    st_wb_activate,
    st_wb_gap,
    st_wb_write,
    st_wb_stream,
    st_wb_recover,
    st_fill_activate,
    st_fill_gap,
    st_fill_read,
    st_fill_wait,
    st_fill_capture,
    st_fill_tag,
    st_fill_settle
  } state_t;

  state_t state;
  logic [7:0] count;
  logic [line_bits-1:0] line_index_q;
  logic store_write_q;
  logic lookup_ok;
  logic lookup_hit;
  sdram_cache_pkg::sdrc_addr_t writeback_addr;
  sdram_cache_pkg::sdrc_addr_t fill_addr;

  // burst start addresses, column bits zero
  assign writeback_addr =
    sdram_cache_pkg::sdrc_addr_t'({cached_tag, line_index, {column_bits{1'b0}}});
  assign fill_addr =
    sdram_cache_pkg::sdrc_addr_t'({address_tag, line_index, {column_bits{1'b0}}});

  // tag readout belongs to the line presented one cycle earlier
  assign lookup_ok = (line_index == line_index_q);
  assign lookup_hit = enable && lookup_ok && hit;

  assign store_write = (state == st_idle) && lookup_hit && (write_enable != '0);
  // a write hit in the previous cycle leaves a stale word in the column register
  assign data_out_ready = (state == st_idle) && lookup_hit && (write_enable == '0)
                          && !store_write_q;
  assign busy = (state != st_idle) || (enable && !(lookup_ok && hit));

  assign fill_active = (state == st_fill_capture) || (state == st_fill_tag);
  assign tag_fill_we = (state == st_fill_tag);

  always_ff @(posedge clk) begin
    line_index_q <= line_index;
    if (!rst_n) begin
      state <= st_init_refresh;
      count <= '0;
      fill_column <= '0;
      fill_we <= 1'b0;
      sdrc_cmd_en <= 1'b0;
      store_write_q <= 1'b0;
    end else begin
      store_write_q <= store_write;
      // command and fill strobes last one cycle
      sdrc_cmd_en <= 1'b0;
      fill_we <= 1'b0;
      case (state)
        st_init_refresh: begin
          if (sdrc_init_done) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= sdram_cache_pkg::cmd_refresh;
            state <= st_init_wait;
          end
        end
        st_init_wait: begin
          if (sdrc_cmd_ack) begin
            state <= st_idle;
          end
        end
        st_idle: begin
          if (enable && lookup_ok && !hit) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= sdram_cache_pkg::cmd_activate;
            fill_column <= '0;
            if (line_dirty) begin
              // evict the resident line first
              sdrc_addr <= writeback_addr;
              state <= st_wb_activate;
            end else begin
              sdrc_addr <= fill_addr;
              state <= st_fill_activate;
            end
          end
        end
        st_wb_activate: begin
          state <= st_wb_gap;
        end
        st_wb_gap: begin
          sdrc_cmd_en <= 1'b1;
          sdrc_cmd <= sdram_cache_pkg::cmd_write;
          sdrc_addr <= writeback_addr;
          sdrc_data_len <= sdram_cache_pkg::data_len_t'(columns - 1);
          sdrc_data <= line_word;
          fill_column <= fill_column + 1'b1;
          state <= st_wb_write;
        end
        st_wb_write: begin
          sdrc_data <= line_word;
          fill_column <= fill_column + 1'b1;
          state <= st_wb_stream;
        end
        st_wb_stream: begin
          sdrc_data <= line_word;
          if (fill_column == '1) begin
            count <= '0;
            state <= st_wb_recover;
          end else begin
            fill_column <= fill_column + 1'b1;
          end
        end
        st_wb_recover: begin
          count <= count + 1'b1;
          if (count == 8'(write_recovery - 1)) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= sdram_cache_pkg::cmd_activate;
            sdrc_addr <= fill_addr;
            state <= st_fill_activate;
          end
        end
        st_fill_activate: begin
          state <= st_fill_gap;
        end
        st_fill_gap: begin
          sdrc_cmd_en <= 1'b1;
          sdrc_cmd <= sdram_cache_pkg::cmd_read;
          sdrc_addr <= fill_addr;
          sdrc_data_len <= sdram_cache_pkg::data_len_t'(columns - 1);
          count <= '0;
          state <= st_fill_read;
        end
        st_fill_read: begin
          state <= st_fill_wait;
        end
        st_fill_wait: begin
          // first word arrives read_latency + 1 cycles after the read strobe
          count <= count + 1'b1;
          if (count == 8'(read_latency - 1)) begin
            count <= '0;
            state <= st_fill_capture;
          end
        end
        st_fill_capture: begin
          fill_data <= sdrc_data_in;
          fill_we <= 1'b1;
          fill_column <= count[column_bits-1:0];
          count <= count + 1'b1;
          if (count == 8'(columns - 1)) begin
            state <= st_fill_tag;
          end
        end
        st_fill_tag: begin
          state <= st_fill_settle;
        end
        st_fill_settle: begin
          // tag and last column read back before the next lookup
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/sdram_cache_data_array.sv */
// data array: one RAM per column, fed by requester writes or line fills
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_data_array #(
  parameter int column_bits = 3,
  parameter int line_bits = 4
) (
  input  wire                              clk,
  input  wire [line_bits-1:0]              line_index,
  input  wire [column_bits-1:0]            column_index,
  input  wire sdram_cache_pkg::word_t      data_in,
  input  wire sdram_cache_pkg::byte_en_t   write_enable,
  input  wire                              store_write,
  input  wire                              fill_active,
  input  wire                              fill_we,
  input  wire [column_bits-1:0]            fill_column,
  input  wire sdram_cache_pkg::word_t      fill_data,
  output sdram_cache_pkg::word_t           data_out,
  output sdram_cache_pkg::word_t           line_word
);

  localparam int columns = 2 ** column_bits;

  sdram_cache_pkg::word_t write_word;
  sdram_cache_pkg::word_t column_out [columns];

  // fill data owns the write port while a line is being loaded
  assign write_word = fill_active ? fill_data : data_in;

  for (genvar c = 0; c < columns; c++) begin : g_column
    sdram_cache_pkg::byte_en_t column_we;

    always_comb begin
      column_we = '0;
      if (fill_active) begin
        if (fill_we && fill_column == column_bits'(c)) begin
          column_we = '1;
        end
      end else if (store_write && column_index == column_bits'(c)) begin
        // byte merge of a write hit
        column_we = write_enable;
      end
    end

    sdram_cache_bram #(
      .address_bits(line_bits)
    ) u_column_ram (
      .clk(clk),
      .write_enable(column_we),
      .address(line_index),
      .data_in(write_word),
      .data_out(column_out[c])
    );
  end

  // all columns read the same line, so the selects can change freely
  assign data_out = column_out[column_index];
  assign line_word = column_out[fill_column];

endmodule

`default_nettype wire

/* design/sdram_cache_pkg.sv */
// sdram cache shared types: data vectors, controller fields and command codes
`default_nettype none

package sdram_cache_pkg;

  // one requester or SDRAM data word
  typedef logic [31:0] word_t;

  // byte write enables, bit n covers byte n of a word
  typedef logic [3:0] byte_en_t;

  // controller command field
  typedef logic [2:0] sdrc_cmd_t;

  // controller word address
  typedef logic [20:0] sdrc_addr_t;

  // burst length minus one
  typedef logic [7:0] data_len_t;

  // SDRAM HS controller command codes
  localparam sdrc_cmd_t cmd_refresh = 3'b001;
  localparam sdrc_cmd_t cmd_activate = 3'b011;
  localparam sdrc_cmd_t cmd_write = 3'b100;
  localparam sdrc_cmd_t cmd_read = 3'b101;

endpackage

`default_nettype wire

/* design/sdram_cache_tag_array.sv */
// tag array: per-line tag, valid and dirty storage with hit detection
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_tag_array #(
  parameter int column_bits = 3,
  parameter int line_bits = 4,
  parameter int ram_addr_bits = 21,
  localparam int tag_bits = ram_addr_bits - line_bits - column_bits
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire [line_bits-1:0] line_index,
  input  wire [tag_bits-1:0]  address_tag,
  input  wire                 tag_fill_we,
  input  wire                 store_write,
  output logic                hit,
  output logic                line_dirty,
  output logic [tag_bits-1:0] cached_tag
);

  // stored word layout is {zero pad, dirty, valid, tag}
  localparam int valid_bit = tag_bits;
  localparam int dirty_bit = tag_bits + 1;

  sdram_cache_pkg::byte_en_t tag_we;
  sdram_cache_pkg::word_t tag_word_in;
  sdram_cache_pkg::word_t tag_word;
  logic [2**line_bits-1:0] valid_lines;
  logic line_valid;

  // a fill writes the line clean, a write hit marks it dirty
  assign tag_we = (tag_fill_we || store_write) ? '1 : '0;
  assign tag_word_in = sdram_cache_pkg::word_t'({store_write, 1'b1, address_tag});

  sdram_cache_bram #(
    .address_bits(line_bits)
  ) u_tag_ram (
    .clk(clk),
    .write_enable(tag_we),
    .address(line_index),
    .data_in(tag_word_in),
    .data_out(tag_word)
  );

  // valid flags live in flops so that RAM contents after power-up never hit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_lines <= '0;
      line_valid <= 1'b0;
    end else begin
      if (tag_fill_we) begin
        valid_lines[line_index] <= 1'b1;
      end
      line_valid <= valid_lines[line_index];
    end
  end

  assign cached_tag = tag_word[tag_bits-1:0];
  assign hit = line_valid && tag_word[valid_bit] && (cached_tag == address_tag);
  assign line_dirty = line_valid && tag_word[dirty_bit];

endmodule

`default_nettype wire

/* design/sdram_cache_top.sv */
// direct-mapped write-back SDRAM cache between a 32-bit requester and a burst controller
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_top #(
  parameter int column_bits = 3,
  parameter int line_bits = 4,
  parameter int ram_addr_bits = 21,
  parameter int read_latency = 4,
  parameter int write_recovery = 4
) (
  input  wire                               clk,
  input  wire                               rst_n,
  // requester
  input  wire                               enable,
  input  wire [31:0]                        address,
  input  wire sdram_cache_pkg::word_t       data_in,
  input  wire sdram_cache_pkg::byte_en_t    write_enable,
  output sdram_cache_pkg::word_t            data_out,
  output logic                              data_out_ready,
  output logic                              busy,
  // SDRAM controller
  output logic                              sdrc_cmd_en,
  output sdram_cache_pkg::sdrc_cmd_t        sdrc_cmd,
  output sdram_cache_pkg::sdrc_addr_t       sdrc_addr,
  output sdram_cache_pkg::word_t            sdrc_data,
  output sdram_cache_pkg::data_len_t        sdrc_data_len,
  input  wire sdram_cache_pkg::word_t       sdrc_data_in,
  input  wire                               sdrc_init_done,
  input  wire                               sdrc_cmd_ack
);

  localparam int tag_bits = ram_addr_bits - line_bits - column_bits;
  // byte address, word aligned
  localparam int column_lsb = 2;
  localparam int line_lsb = column_lsb + column_bits;
  localparam int tag_lsb = line_lsb + line_bits;

  logic [column_bits-1:0] column_index;
  logic [line_bits-1:0] line_index;
  logic [tag_bits-1:0] address_tag;
  logic hit;
  logic line_dirty;
  logic [tag_bits-1:0] cached_tag;
  sdram_cache_pkg::word_t line_word;
  logic store_write;
  logic fill_active;
  logic fill_we;
  logic [column_bits-1:0] fill_column;
  sdram_cache_pkg::word_t fill_data;
  logic tag_fill_we;

  // |tag|line|column|00|
  assign column_index = address[column_lsb +: column_bits];
  assign line_index = address[line_lsb +: line_bits];
  assign address_tag = address[tag_lsb +: tag_bits];

  sdram_cache_ctrl #(
    .column_bits(column_bits),
    .line_bits(line_bits),
    .ram_addr_bits(ram_addr_bits),
    .read_latency(read_latency),
    .write_recovery(write_recovery)
  ) u_ctrl (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .write_enable(write_enable),
    .address_tag(address_tag),
    .line_index(line_index),
    .hit(hit),
    .line_dirty(line_dirty),
    .cached_tag(cached_tag),
    .line_word(line_word),
    .busy(busy),
    .data_out_ready(data_out_ready),
    .store_write(store_write),
    .fill_active(fill_active),
    .fill_we(fill_we),
    .fill_column(fill_column),
    .fill_data(fill_data),
    .tag_fill_we(tag_fill_we),
    .sdrc_cmd_en(sdrc_cmd_en),
    .sdrc_cmd(sdrc_cmd),
    .sdrc_addr(sdrc_addr),
    .sdrc_data(sdrc_data),
    .sdrc_data_len(sdrc_data_len),
    .sdrc_data_in(sdrc_data_in),
    .sdrc_init_done(sdrc_init_done),
    .sdrc_cmd_ack(sdrc_cmd_ack)
  );

  sdram_cache_tag_array #(
    .column_bits(column_bits),
    .line_bits(line_bits),
    .ram_addr_bits(ram_addr_bits)
  ) u_tag_array (
    .clk(clk),
    .rst_n(rst_n),
    .line_index(line_index),
    .address_tag(address_tag),
    .tag_fill_we(tag_fill_we),
    .store_write(store_write),
    .hit(hit),
    .line_dirty(line_dirty),
    .cached_tag(cached_tag)
  );

  sdram_cache_data_array #(
    .column_bits(column_bits),
    .line_bits(line_bits)
  ) u_data_array (
    .clk(clk),
    .line_index(line_index),
    .column_index(column_index),
    .data_in(data_in),
    .write_enable(write_enable),
    .store_write(store_write),
    .fill_active(fill_active),
    .fill_we(fill_we),
    .fill_column(fill_column),
    .fill_data(fill_data),
    .data_out(data_out),
    .line_word(line_word)
  );

endmodule

`default_nettype wire

/* sdram_cache.f */
design/sdram_cache_pkg.sv
design/sdram_cache_bram.sv
design/sdram_cache_tag_array.sv
design/sdram_cache_data_array.sv
design/sdram_cache_ctrl.sv
design/sdram_cache_top.sv
verification/sdrc_model.sv
verification/sdram_cache_checker.sv
verification/tb_sdram_cache.sv

/* verification/sdram_cache_checker.sv */
// cache checker: shadow memory, read compare, eviction and handshake rules
`timescale 1ns/1ps
`default_nettype none

module sdram_cache_checker #(
  parameter int column_bits = 3,
  parameter int line_bits = 4,
  parameter int mem_words = 4096
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               enable,
  input  wire [31:0]                        address,
  input  wire sdram_cache_pkg::word_t       data_in,
  input  wire sdram_cache_pkg::byte_en_t    write_enable,
  input  wire sdram_cache_pkg::word_t       data_out,
  input  wire                               data_out_ready,
  input  wire                               busy,
  input  wire                               sdrc_cmd_en,
  input  wire sdram_cache_pkg::sdrc_cmd_t   sdrc_cmd,
  input  wire sdram_cache_pkg::sdrc_addr_t  sdrc_addr,
  input  wire                               sdrc_cmd_ack,
  output int                                error_count,
  output int                                read_count
);

  localparam int lines = 2 ** line_bits;
  localparam logic [31:0] pattern_key = 32'ha5c3_0f69;

  string test_name = "none";
  sdram_cache_pkg::word_t shadow [mem_words];
  logic [31:0] line_tag [lines];
  logic line_valid [lines];
  logic line_dirty [lines];
  logic init_seen;

  // expected word after a byte-enabled write
  function automatic sdram_cache_pkg::word_t merge_bytes(
    input sdram_cache_pkg::word_t old_word,
    input sdram_cache_pkg::word_t new_word,
    input sdram_cache_pkg::byte_en_t byte_en
  );
    sdram_cache_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (byte_en[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  always @(negedge clk) begin
    int unsigned waddr;
    int unsigned idx;
    int unsigned line;
    int unsigned wb_line;
    logic [31:0] tag;
    logic [31:0] wb_tag;
    sdram_cache_pkg::word_t expected;
    waddr = 32'(address[31:2]);
    idx = waddr % mem_words;
    line = (waddr >> column_bits) % lines;
    tag = waddr >> (column_bits + line_bits);
    if (!rst_n) begin
      for (int i = 0; i < mem_words; i++) begin
        shadow[i] = 32'(i) ^ pattern_key;
      end
      for (int l = 0; l < lines; l++) begin
        line_valid[l] = 1'b0;
        line_dirty[l] = 1'b0;
        line_tag[l] = '0;
      end
      init_seen = 1'b0;
      error_count = 0;
      read_count = 0;
    end else begin
      if (!init_seen && !busy) begin
        $display("busy dropped before the init refresh was acknowledged");
        error_count++;
        init_seen = 1'b1;
      end
      if (sdrc_cmd_ack) begin
        init_seen = 1'b1;
      end
      if (data_out_ready && write_enable != '0) begin
        $display("data_out_ready rose during a write to address %h", address);
        error_count++;
      end
      // a write burst must evict the dirty resident line
      if (sdrc_cmd_en && sdrc_cmd == sdram_cache_pkg::cmd_write) begin
        wb_line = (32'(sdrc_addr) >> column_bits) % lines;
        wb_tag = 32'(sdrc_addr) >> (column_bits + line_bits);
        if (!line_valid[wb_line] || !line_dirty[wb_line]) begin
          $display("write burst seen for clean line %0d in test %s", wb_line, test_name);
          error_count++;
        end else if (line_tag[wb_line] != wb_tag) begin
          $display("write-back address does not belong to line %0d", wb_line);
          error_count++;
        end
        line_dirty[wb_line] = 1'b0;
      end
      if (enable && !busy && write_enable != '0) begin
        shadow[idx] = merge_bytes(shadow[idx], data_in, write_enable);
        line_tag[line] = tag;
        line_valid[line] = 1'b1;
        line_dirty[line] = 1'b1;
      end
      if (data_out_ready && write_enable == '0) begin
        read_count++;
        expected = shadow[idx];
        if (data_out !== expected) begin
          $display("Fail %s address %h expected %h actual %h",
                   test_name, address, expected, data_out);
          error_count++;
        end
        // a read of another tag went through a fill, so the line is clean
        if (!line_valid[line] || line_tag[line] != tag) begin
          line_dirty[line] = 1'b0;
        end
        line_tag[line] = tag;
        line_valid[line] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/sdrc_model.sv */
// behavioral SDRAM HS controller with refresh ack, burst write capture and delayed burst read
`timescale 1ns/1ps
`default_nettype none

module sdrc_model #(
  parameter int read_latency = 4,
  parameter int mem_words = 4096
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               sdrc_cmd_en,
  input  wire sdram_cache_pkg::sdrc_cmd_t   sdrc_cmd,
  input  wire sdram_cache_pkg::sdrc_addr_t  sdrc_addr,
  input  wire sdram_cache_pkg::word_t       sdrc_data,
  input  wire sdram_cache_pkg::data_len_t   sdrc_data_len,
  output sdram_cache_pkg::word_t            sdrc_data_in,
  output logic                              sdrc_init_done,
  output logic                              sdrc_cmd_ack
);

  localparam logic [31:0] pattern_key = 32'ha5c3_0f69;

  sdram_cache_pkg::word_t mem [mem_words];
  int init_count;
  logic wr_active;
  int wr_left;
  int unsigned wr_addr;
  logic rd_active;
  int rd_cycle;
  int rd_len;
  int unsigned rd_addr;

  always @(posedge clk) begin
    if (!rst_n) begin
      // word address pattern so that every word differs
      for (int i = 0; i < mem_words; i++) begin
        mem[i] = 32'(i) ^ pattern_key;
      end
      init_count = 0;
      wr_active = 1'b0;
      rd_active = 1'b0;
      sdrc_init_done <= 1'b0;
      sdrc_cmd_ack <= 1'b0;
      sdrc_data_in <= '0;
    end else begin
      sdrc_cmd_ack <= 1'b0;
      if (init_count < 8) begin
        init_count++;
      end else begin
        sdrc_init_done <= 1'b1;
      end
      // remaining words of a write burst arrive one per cycle
      if (wr_active) begin
        mem[wr_addr % mem_words] = sdrc_data;
        wr_addr++;
        wr_left--;
        if (wr_left == 0) begin
          wr_active = 1'b0;
        end
      end
      // read words land read_latency + 1 cycles after the command cycle
      if (rd_active) begin
        rd_cycle++;
        if (rd_cycle >= read_latency && rd_cycle < read_latency + rd_len) begin
          sdrc_data_in <= mem[(rd_addr + 32'(rd_cycle - read_latency)) % mem_words];
        end
        if (rd_cycle >= read_latency + rd_len) begin
          rd_active = 1'b0;
        end
      end
      if (sdrc_cmd_en) begin
        case (sdrc_cmd)
          sdram_cache_pkg::cmd_refresh: begin
            sdrc_cmd_ack <= 1'b1;
          end
          sdram_cache_pkg::cmd_write: begin
            // first word comes with the command
            mem[32'(sdrc_addr) % mem_words] = sdrc_data;
            wr_addr = 32'(sdrc_addr) + 1;
            wr_left = int'(sdrc_data_len);
            wr_active = (sdrc_data_len != '0);
          end
          sdram_cache_pkg::cmd_read: begin
            rd_active = 1'b1;
            rd_cycle = 0;
            rd_addr = 32'(sdrc_addr);
            rd_len = int'(sdrc_data_len) + 1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verification/tb_sdram_cache.sv */
// SDRAM cache testbench with clock, reset, requester tasks, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_cache;

  localparam int column_bits = 3;
  localparam int line_bits = 4;
  localparam int read_latency = 4;
  localparam int write_recovery = 4;
  localparam int clk_period = 20;
  localparam int access_count = 240;
  // dirty miss bound plus handshake cycles
  localparam int access_bound = read_latency + 2 * (2 ** column_bits) + write_recovery + 13;
  localparam int watchdog_cycles = access_count * access_bound + 500;

  logic clk;
  logic rst_n;
  logic enable;
  logic [31:0] address;
  sdram_cache_pkg::word_t data_in;
  sdram_cache_pkg::byte_en_t write_enable;
  sdram_cache_pkg::word_t data_out;
  logic data_out_ready;
  logic busy;
  logic sdrc_cmd_en;
  sdram_cache_pkg::sdrc_cmd_t sdrc_cmd;
  sdram_cache_pkg::sdrc_addr_t sdrc_addr;
  sdram_cache_pkg::word_t sdrc_data;
  sdram_cache_pkg::data_len_t sdrc_data_len;
  sdram_cache_pkg::word_t sdrc_data_in;
  logic sdrc_init_done;
  logic sdrc_cmd_ack;
  int error_count;
  int read_count;
  int tb_errors;
  int test_count;
  int start_errors;
  int seed;

  sdram_cache_top #(
    .column_bits(column_bits),
    .line_bits(line_bits),
    .ram_addr_bits(21),
    .read_latency(read_latency),
    .write_recovery(write_recovery)
  ) i_dut (
    .clk(clk), .rst_n(rst_n), .enable(enable), .address(address),
    .data_in(data_in), .write_enable(write_enable), .data_out(data_out),
    .data_out_ready(data_out_ready), .busy(busy),
    .sdrc_cmd_en(sdrc_cmd_en), .sdrc_cmd(sdrc_cmd), .sdrc_addr(sdrc_addr),
    .sdrc_data(sdrc_data), .sdrc_data_len(sdrc_data_len),
    .sdrc_data_in(sdrc_data_in), .sdrc_init_done(sdrc_init_done),
    .sdrc_cmd_ack(sdrc_cmd_ack)
  );

  sdrc_model #(
    .read_latency(read_latency)
  ) i_sdrc (
    .clk(clk), .rst_n(rst_n), .sdrc_cmd_en(sdrc_cmd_en), .sdrc_cmd(sdrc_cmd),
    .sdrc_addr(sdrc_addr), .sdrc_data(sdrc_data), .sdrc_data_len(sdrc_data_len),
    .sdrc_data_in(sdrc_data_in), .sdrc_init_done(sdrc_init_done),
    .sdrc_cmd_ack(sdrc_cmd_ack)
  );

  sdram_cache_checker #(
    .column_bits(column_bits),
    .line_bits(line_bits)
  ) i_checker (
    .clk(clk), .rst_n(rst_n), .enable(enable), .address(address),
    .data_in(data_in), .write_enable(write_enable), .data_out(data_out),
    .data_out_ready(data_out_ready), .busy(busy), .sdrc_cmd_en(sdrc_cmd_en),
    .sdrc_cmd(sdrc_cmd), .sdrc_addr(sdrc_addr), .sdrc_cmd_ack(sdrc_cmd_ack),
    .error_count(error_count), .read_count(read_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Some tests failed");
    $finish;
  end

  function automatic int total_errors();
    return error_count + tb_errors;
  endfunction

  task automatic start_test(input string name);
    i_checker.test_name = name;
    start_errors = total_errors();
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - start_errors;
    test_count++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // hold the request until busy is low on two cycles in a row
  task automatic finish_access(input logic is_read);
    int low_cycles;
    int cycles;
    logic seen_ready;
    low_cycles = 0;
    cycles = 0;
    seen_ready = 1'b0;
    forever begin
      @(negedge clk);
      cycles++;
      if (data_out_ready) seen_ready = 1'b1;
      low_cycles = busy ? 0 : low_cycles + 1;
      if (low_cycles >= 2 && (seen_ready || !is_read)) break;
      if (cycles > access_bound) begin
        $display("access to address %h did not complete", address);
        tb_errors++;
        break;
      end
    end
    @(posedge clk);
    #2;
    enable = 1'b0;
    write_enable = '0;
  endtask

  task automatic read_word(input int unsigned word_addr);
    @(posedge clk);
    #2;
    enable = 1'b1;
    address = word_addr << 2;
    write_enable = '0;
    finish_access(1'b1);
  endtask

  task automatic write_word(input int unsigned word_addr, input sdram_cache_pkg::word_t value,
                            input sdram_cache_pkg::byte_en_t byte_en);
    @(posedge clk);
    #2;
    enable = 1'b1;
    address = word_addr << 2;
    data_in = value;
    write_enable = byte_en;
    finish_access(1'b0);
  endtask

  initial begin
    int unsigned waddr;
    sdram_cache_pkg::byte_en_t be;
    int cycles;
    seed = 93600;
    tb_errors = 0;
    test_count = 0;
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start_test("init");
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (busy && cycles < 100);
    if (busy) begin
      $display("busy never dropped after reset");
      tb_errors++;
    end
    end_test("init");

    start_test("cold_line");
    for (int c = 0; c < 8; c++) read_word(32'h400 + c);
    end_test("cold_line");

    start_test("byte_merge");
    write_word(32'h410, 32'h1122_3344, 4'b0101);
    read_word(32'h410);
    end_test("byte_merge");

    // same line index with a tag one higher
    start_test("write_back");
    for (int c = 0; c < 8; c++) write_word(32'h420 + c, $random(seed), 4'b1111);
    read_word(32'h4a0);
    for (int c = 0; c < 8; c++) read_word(32'h420 + c);
    end_test("write_back");

    start_test("clean_evict");
    read_word(32'h430);
    read_word(32'h4b0);
    read_word(32'h430);
    read_word(32'h437);
    end_test("clean_evict");

    start_test("random");
    for (int n = 0; n < 200; n++) begin
      waddr = $random(seed) & 511;
      if ($random(seed) & 1) begin
        be = $random(seed) & 15;
        if (be == '0) be = 4'b0001;
        write_word(waddr, $random(seed), be);
      end else begin
        read_word(waddr);
      end
    end
    end_test("random");

    $display("%0d tests, %0d reads checked, %0d errors", test_count, read_count,
             total_errors());
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
